//--- verilog.f
design/isa_pkg.sv
design/dmem_pkg.sv
design/access_ctrl.sv
design/store_merge.sv
design/load_align.sv
design/data_ram.sv
design/result_reg.sv
design/mem_stage.sv
bench/mem_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the memory-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mem_stage_tb \
  -f verilog.f -o mem_stage_sim

result=$(./obj_dir/mem_stage_sim || true)
echo "$result"

if echo "$result" | grep -qx "All tests passed!"; then
  exit 0
else
  exit 1
fi

//--- bench/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;
  import isa_pkg::*;
  import dmem_pkg::*;

  localparam int MAX_INSTR = 40;
  localparam int WATCHDOG_NS = MAX_INSTR * 4 * 8 + 400;  // worst case of 4 cycles at 8 ns

  logic        clk = 1'b0;
  logic        reset;
  logic        flush;
  logic        in_valid;
  mem_instr_t  instr;
  logic        ready;
  mem_result_t out;

  int          seed = 32'h6ae7_f467;
  logic [63:0] shadow [DMEM_WORDS];
  int          pool [8];  // word indices in use

  // model state for the checks
  int          wait_cnt;
  int          exp_lat;
  logic [63:0] cur_mdata;
  logic [63:0] exp_mdata_q;
  mem_instr_t  exp_q;
  logic        acc_q;

  mem_stage mem_stage_i (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .in_valid (in_valid),
    .in       (instr),
    .ready    (ready),
    .out      (out)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (reset || !in_valid || ready || flush) begin
      wait_cnt <= 0;
    end else begin
      wait_cnt <= wait_cnt + 1;
    end
    acc_q <= !reset && in_valid && ready && !flush;
    exp_q <= instr;
    exp_mdata_q <= cur_mdata;
  end

  task automatic report_fail(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  a_reset_quiet: assert property (@(posedge clk) reset |=> !out.valid)
    else report_fail("out.valid high during or right after reset");

  a_latency: assert property (@(posedge clk) disable iff (reset)
    in_valid && ready && !flush |-> wait_cnt == exp_lat)
    else report_fail($sformatf("ready after %0d cycles, expected %0d",
                               $sampled(wait_cnt), $sampled(exp_lat)));

  a_valid_pulse: assert property (@(posedge clk) disable iff (reset) out.valid == acc_q)
    else report_fail("out.valid does not follow the accepted instructions");

  a_fields: assert property (@(posedge clk) disable iff (reset)
    acc_q |-> out.op == exp_q.op && out.alu_result == exp_q.alu_result &&
              out.rs2_value == exp_q.rs2_value && out.rd == exp_q.rd &&
              out.update_rd == exp_q.update_rd && out.load_bool == exp_q.load_bool &&
              out.branch_taken == exp_q.branch_taken && out.pc_target == exp_q.pc_target)
    else report_fail("instruction fields not copied to out");

  a_mdata: assert property (@(posedge clk) disable iff (reset)
    acc_q |-> out.mdata == exp_mdata_q)
    else report_fail($sformatf("mdata %h, expected %h",
                               $sampled(out.mdata), $sampled(exp_mdata_q)));

  a_flush_ready: assert property (@(posedge clk) disable iff (reset) flush |-> ready)
    else report_fail("ready low while flush is high");

  a_flush_clear: assert property (@(posedge clk) disable iff (reset) flush |=> out == '0)
    else report_fail("out not cleared after flush");

  function automatic int size_of(input mem_op_t op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic int latency(input mem_op_t op);
    case (op)
      op_none: return 0;
      op_sb, op_sh, op_sw: return 3;  // read then write
      default: return 1;
    endcase
  endfunction

  function automatic mem_op_t pick_load(input int n);
    case (n % 6)
      0: return op_lb;
      1: return op_lbu;
      2: return op_lh;
      3: return op_lhu;
      4: return op_lw;
      default: return op_lwu;
    endcase
  endfunction

  function automatic logic [63:0] load_value(input mem_op_t op, input logic [63:0] word,
                                             input int off);
    logic [63:0] v;
    v = word >> (8 * off);
    case (op)
      op_lb: return {{56{v[7]}}, v[7:0]};
      op_lbu: return {56'd0, v[7:0]};
      op_lh: return {{48{v[15]}}, v[15:0]};
      op_lhu: return {48'd0, v[15:0]};
      op_lw: return {{32{v[31]}}, v[31:0]};
      op_lwu: return {32'd0, v[31:0]};
      op_ld: return word;
      default: return 64'd0;
    endcase
  endfunction

  // returns old unchanged for anything that is not a store
  function automatic logic [63:0] merge_store(input logic [63:0] old, input mem_op_t op,
                                              input int off, input logic [63:0] data);
    logic [63:0] mask;
    case (op)
      op_sb: mask = 64'hff;
      op_sh: mask = 64'hffff;
      op_sw: mask = 64'hffff_ffff;
      op_sd: mask = '1;
      default: mask = '0;
    endcase
    mask = mask << (8 * off);
    return (old & ~mask) | ((data << (8 * off)) & mask);
  endfunction

  task automatic build_instr(input mem_op_t op, input int idx, input int off,
                             input logic [63:0] data, output mem_instr_t ins);
    int r;
    r = $random(seed);
    ins = '0;
    ins.op = op;
    ins.alu_result = {$random(seed), $random(seed)};  // high bits are don't-care
    ins.alu_result[LANE_W +: DMEM_IDX_W] = idx[DMEM_IDX_W-1:0];
    ins.alu_result[LANE_W-1:0] = off[LANE_W-1:0];
    ins.rs2_value = data;
    ins.rd = r[4:0];
    ins.update_rd = r[5];
    ins.load_bool = (op >= op_lb && op <= op_ld);
    ins.branch_taken = r[6];
    ins.pc_target = {$random(seed), $random(seed)};
  endtask

  // present one instruction and hold it until ready is seen at an edge
  task automatic issue(input mem_op_t op, input int idx, input int off,
                       input logic [63:0] data);
    mem_instr_t ins;
    build_instr(op, idx, off, data, ins);
    cur_mdata = load_value(op, shadow[idx], off);
    exp_lat = latency(op);
    instr = ins;
    in_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!ready);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    shadow[idx] = merge_store(shadow[idx], op, off, data);
  endtask

  // sub-word store cancelled by flush in cycle k after it was presented
  task automatic flush_store(input mem_op_t op, input int idx, input int off,
                             input logic [63:0] data, input int k);
    mem_instr_t ins;
    build_instr(op, idx, off, data, ins);
    cur_mdata = 64'd0;
    exp_lat = latency(op);
    instr = ins;
    in_valid = 1'b1;
    repeat (k) begin
      @(posedge clk);
      #1;
    end
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    in_valid = 1'b0;
    if (k >= 3) shadow[idx] = merge_store(shadow[idx], op, off, data);  // write went out in cycle 2
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $fatal(1);
  end

  initial begin
    int idx;
    int off;
    mem_op_t op;
    reset = 1'b1;
    flush = 1'b0;
    in_valid = 1'b0;
    instr = '0;
    cur_mdata = 64'd0;
    exp_lat = 0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < 8; i++) begin
      pool[i] = $random(seed) & 255;
      issue(op_sd, pool[i], 0, {$random(seed), $random(seed)});
    end

    issue(op_none, pool[0], 0, {$random(seed), $random(seed)});
    issue(op_none, pool[1], 0, {$random(seed), $random(seed)});

    for (int i = 0; i < 2; i++) begin
      idx = pool[$random(seed) & 7];
      issue(op_sd, idx, 0, {$random(seed), $random(seed)});
      issue(op_ld, idx, 0, 64'd0);
    end

    for (int i = 0; i < 12; i++) begin
      op = pick_load(i);
      idx = pool[$random(seed) & 7];
      off = ($random(seed) & 7) & ~(size_of(op) - 1);
      issue(op, idx, off, 64'd0);
    end

    for (int i = 0; i < 3; i++) begin
      op = (i == 0) ? op_sb : (i == 1) ? op_sh : op_sw;
      idx = pool[$random(seed) & 7];
      off = ($random(seed) & 7) & ~(size_of(op) - 1);
      issue(op, idx, off, {$random(seed), $random(seed)});
      issue(op_ld, idx, 0, 64'd0);
    end

    // flush in cycles 1, 2 and 3 of a read-modify-write
    for (int k = 1; k <= 3; k++) begin
      op = (k == 1) ? op_sw : (k == 2) ? op_sh : op_sb;
      idx = pool[$random(seed) & 7];
      off = ($random(seed) & 7) & ~(size_of(op) - 1);
      flush_store(op, idx, off, {$random(seed), $random(seed)}, k);
      issue(op_ld, idx, 0, 64'd0);
    end

    repeat (3) @(posedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 in_valid,
  input  isa_pkg::mem_instr_t  in,
  output logic                 ready,
  output isa_pkg::mem_result_t out
);
  import dmem_pkg::*;

  dmem_req_t                     req;
  dmem_resp_t                    resp;
  dmem_word_u                    merged;
  logic                          capture;
  logic [$bits(in.rs2_value)-1:0] mdata;  // register width

  access_ctrl access_ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .in_valid (in_valid),
    .in       (in),
    .resp     (resp),
    .merged   (merged),
    .req      (req),
    .capture  (capture),
    .done     (ready)
  );

  store_merge store_merge_i (
    .clk         (clk),
    .capture     (capture),
    .old_word    (resp.rdata),
    .op          (in.op),
    .addr_lane   (in.alu_result[LANE_W-1:0]),
    .store_value (in.rs2_value),
    .merged      (merged)
  );

  load_align load_align_i (
    .word      (resp.rdata),
    .op        (in.op),
    .addr_lane (in.alu_result[LANE_W-1:0]),
    .mdata     (mdata)
  );

  data_ram data_ram_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .resp  (resp)
  );

  // ready doubles as the load strobe
  result_reg result_reg_i (
    .clk   (clk),
    .reset (reset),
    .flush (flush),
    .load  (ready),
    .in    (in),
    .mdata (mdata),
    .out   (out)
  );

endmodule

//--- design/result_reg.sv
`timescale 1ns/1ps

module result_reg (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     load,
  input  isa_pkg::mem_instr_t      in,
  input  logic [isa_pkg::XLEN-1:0] mdata,
  output isa_pkg::mem_result_t     out
);
  import isa_pkg::*;

  mem_result_t next;

  always_comb begin
    next.valid = 1'b1;
    next.op = in.op;
    next.alu_result = in.alu_result;
    next.rs2_value = in.rs2_value;
    next.mdata = mdata;
    next.rd = in.rd;
    next.update_rd = in.update_rd;
    next.load_bool = in.load_bool;
    next.branch_taken = in.branch_taken;
    next.pc_target = in.pc_target;
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      out <= '0;
    end else if (load) begin
      out <= next;
    end else begin
      out.valid <= 1'b0;  // payload stays, one-cycle valid pulse
    end
  end

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input  logic                 clk,
  input  logic                 reset,
  input  dmem_pkg::dmem_req_t  req,
  output dmem_pkg::dmem_resp_t resp
);
  import dmem_pkg::*;

  dmem_word_u mem [DMEM_WORDS];

  always_ff @(posedge clk) begin
    if (req.valid && req.write) begin
      mem[req.index] <= req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (req.valid) begin
      resp.rdata <= mem[req.index];  // old contents on a write
    end
    if (reset) begin
      resp.valid <= 1'b0;
    end else begin
      resp.valid <= req.valid;  // reads and writes both answer
    end
  end

endmodule

//--- design/load_align.sv
`timescale 1ns/1ps

module load_align (
  input  dmem_pkg::dmem_word_u        word,
  input  isa_pkg::mem_op_t            op,
  input  logic [dmem_pkg::LANE_W-1:0] addr_lane,
  output logic [isa_pkg::XLEN-1:0]    mdata
);
  import isa_pkg::*;
  import dmem_pkg::*;

  logic [7:0]  lane_b;
  logic [15:0] lane_h;
  logic [31:0] lane_w;

  assign lane_b = word.bytes[addr_lane];
  assign lane_h = word.halves[addr_lane[LANE_W-1:1]];
  assign lane_w = word.words[addr_lane[LANE_W-1]];

  always_comb begin
    case (op)
      op_lb:   mdata = {{(XLEN-8){lane_b[7]}}, lane_b};
      op_lbu:  mdata = {{(XLEN-8){1'b0}}, lane_b};
      op_lh:   mdata = {{(XLEN-16){lane_h[15]}}, lane_h};
      op_lhu:  mdata = {{(XLEN-16){1'b0}}, lane_h};
      op_lw:   mdata = {{(XLEN-32){lane_w[31]}}, lane_w};
      op_lwu:  mdata = {{(XLEN-32){1'b0}}, lane_w};
      op_ld:   mdata = word.dword;
      default: mdata = '0;  // stores and non-memory ops
    endcase
  end

endmodule

//--- design/store_merge.sv
`timescale 1ns/1ps

module store_merge (
  input  logic                              clk,
  input  logic                              capture,
  input  dmem_pkg::dmem_word_u              old_word,
  input  isa_pkg::mem_op_t                  op,
  input  logic [dmem_pkg::LANE_W-1:0]       addr_lane,
  input  logic [isa_pkg::XLEN-1:0]          store_value,
  output dmem_pkg::dmem_word_u              merged
);
  import isa_pkg::*;
  import dmem_pkg::*;

  dmem_word_u held;  // word from the read half

  always_ff @(posedge clk) begin
    if (capture) begin
      held <= old_word;
    end
  end

  always_comb begin
    merged = held;
    case (op)
      op_sb: merged.bytes[addr_lane] = store_value[7:0];
      op_sh: merged.halves[addr_lane[LANE_W-1:1]] = store_value[15:0];
      op_sw: merged.words[addr_lane[LANE_W-1]] = store_value[31:0];
      op_sd: merged.dword = store_value;  // whole word, old data not needed
      default: ;
    endcase
  end

  // misaligned halves and words would straddle lanes
  a_lane_aligned: assert property (@(posedge clk)
    capture |-> (op != op_sh || !addr_lane[0]) && (op != op_sw || addr_lane[1:0] == 2'b00));

endmodule

//--- design/access_ctrl.sv
`timescale 1ns/1ps

module access_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 in_valid,
  input  isa_pkg::mem_instr_t  in,
  input  dmem_pkg::dmem_resp_t resp,
  input  dmem_pkg::dmem_word_u merged,
  output dmem_pkg::dmem_req_t  req,
  output logic                 capture,
  output logic                 done
);
  import isa_pkg::*;
  import dmem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_read,
    st_write,
    st_wait_write
  } state_t;

  typedef enum logic [1:0] {
    cls_none,
    cls_load,
    cls_full,  // sd is written straight through
    cls_sub    // sb/sh/sw need a read-modify-write
  } op_class_t;

  state_t                state;
  state_t                state_nxt;
  op_class_t             op_class;
  logic [DMEM_IDX_W-1:0] index;

  always_comb begin
    case (in.op)
      op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld: op_class = cls_load;
      op_sd: op_class = cls_full;
      op_sb, op_sh, op_sw: op_class = cls_sub;
      default: op_class = cls_none;
    endcase
  end

  assign index = in.alu_result[LANE_W +: DMEM_IDX_W];  // upper address bits dropped

  always_comb begin
    state_nxt = state;
    req.valid = 1'b0;
    req.write = 1'b0;
    req.index = index;
    req.wdata = merged;
    capture = 1'b0;
    done = 1'b0;
    case (state)
      st_idle: begin
        if (in_valid) begin
          case (op_class)
            cls_none: done = 1'b1;
            cls_full: begin
              req.valid = 1'b1;
              req.write = 1'b1;
              state_nxt = st_wait_write;
            end
            default: begin  // loads and the read half of a sub-word store
              req.valid = 1'b1;
              state_nxt = st_wait_read;
            end
          endcase
        end
      end
      st_wait_read: begin
        if (resp.valid) begin
          if (op_class == cls_sub) begin
            capture = 1'b1;
            state_nxt = st_write;
          end else begin
            done = 1'b1;
            state_nxt = st_idle;
          end
        end
      end
      st_write: begin
        req.valid = 1'b1;
        req.write = 1'b1;
        state_nxt = st_wait_write;
      end
      default: begin
        if (resp.valid) begin  // write ack
          done = 1'b1;
          state_nxt = st_idle;
        end
      end
    endcase
    if (flush) begin
      req.valid = 1'b0;
      req.write = 1'b0;
      capture = 1'b0;
      done = 1'b1;
      state_nxt = st_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // RAM handles a single access at a time
  a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
    req.valid |-> !resp.valid);

  // a write other than sd is the second half of a read-modify-write of the same word
  a_write_source: assert property (@(posedge clk) disable iff (reset)
    req.valid && req.write && in.op != op_sd |->
      $past(req.valid, 2) && !$past(req.write, 2) && $past(req.index, 2) == req.index);

endmodule

//--- design/dmem_pkg.sv
package dmem_pkg;

  localparam int DMEM_WORDS = 256;
  localparam int DMEM_IDX_W = 8;
  localparam int LANE_W = 3;  // byte offset inside a 64-bit word

  // one RAM word, seen at every access size
  typedef union packed {
    logic [7:0][7:0]  bytes;
    logic [3:0][15:0] halves;
    logic [1:0][31:0] words;
    logic [63:0]      dword;
  } dmem_word_u;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [DMEM_IDX_W-1:0] index;
    dmem_word_u            wdata;
  } dmem_req_t;

  // comes back exactly one cycle after each request
  typedef struct packed {
    logic       valid;
    dmem_word_u rdata;
  } dmem_resp_t;

endpackage

//--- design/isa_pkg.sv
package isa_pkg;

  localparam int XLEN = 64;
  localparam int REGNO_W = 5;

  // memory operation carried down from decode
  typedef enum logic [3:0] {
    op_none,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_t;

  typedef struct packed {
    mem_op_t             op;
    logic [XLEN-1:0]     alu_result;  // effective address for loads and stores
    logic [XLEN-1:0]     rs2_value;   // store data
    logic [REGNO_W-1:0]  rd;
    logic                update_rd;
    logic                load_bool;
    logic                branch_taken;
    logic [XLEN-1:0]     pc_target;
  } mem_instr_t;

  // registered toward writeback
  typedef struct packed {
    logic                valid;
    mem_op_t             op;
    logic [XLEN-1:0]     alu_result;
    logic [XLEN-1:0]     rs2_value;
    logic [XLEN-1:0]     mdata;       // zero unless a load
    logic [REGNO_W-1:0]  rd;
    logic                update_rd;
    logic                load_bool;
    logic                branch_taken;
    logic [XLEN-1:0]     pc_target;
  } mem_result_t;

endpackage
